/* hw/ex_pkg.sv */
`default_nettype none

package ex_pkg;

	// --------------------------------------------------
	// widths and flag positions
	// --------------------------------------------------
	localparam int DATA_W = 32;

	localparam int FLAG_CF = 0;
	localparam int FLAG_PF = 2;
	localparam int FLAG_AF = 4;
	localparam int FLAG_ZF = 6;
	localparam int FLAG_SF = 7;
	localparam int FLAG_OF = 11;

	// --------------------------------------------------
	// decoded operation and operand size
	// --------------------------------------------------
	// bit 0 doubles as shift direction when the shifter is chosen
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_OR     = 3'd1,
		ALU_ADC    = 3'd2,
		ALU_AND    = 3'd3,
		ALU_SUB    = 3'd4,
		ALU_XOR    = 3'd5,
		ALU_NOT    = 3'd6,
		ALU_PASS_B = 3'd7
	} alu_op_e;

	typedef enum logic [1:0] {
		SIZE_BYTE  = 2'd0,
		SIZE_WORD  = 2'd1,
		SIZE_DWORD = 2'd2
	} data_size_e;

	// stack pop increment
	function automatic logic [DATA_W-1:0] size_bytes(input data_size_e size);
		case (size)
			SIZE_BYTE: return DATA_W'(1);
			SIZE_WORD: return DATA_W'(2);
			default:   return DATA_W'(4);
		endcase
	endfunction

	// live bits of a word at the operand size
	function automatic logic [DATA_W-1:0] size_mask(input data_size_e size);
		case (size)
			SIZE_BYTE: return DATA_W'(32'h0000_00ff);
			SIZE_WORD: return DATA_W'(32'h0000_ffff);
			default:   return {DATA_W{1'b1}};
		endcase
	endfunction

	function automatic logic sign_bit(input logic [DATA_W-1:0] v, input data_size_e size);
		case (size)
			SIZE_BYTE: return v[7];
			SIZE_WORD: return v[15];
			default:   return v[DATA_W-1];
		endcase
	endfunction

endpackage

`default_nettype wire

/* hw/ex_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface ex_ctrl_if;
	import ex_pkg::*;

	// string micro-op sequencing
	logic       is_cmps_first;
	logic       is_cmps_second;
	logic       repne_steady;
	logic       repne;

	// result routing
	logic       is_cmpxchg;
	logic       is_xchg;
	logic       pass_a;
	logic       mux_sp_pop;
	logic       flags_from_alu;
	logic       alu_to_b;
	logic       is_alu32;

	alu_op_e    aluk;
	data_size_e size;

	// write-back enables from decode
	logic       ld_gpr1;
	logic       ld_gpr2;
	logic       ld_gpr3;
	logic       ld_seg;
	logic       dcache_write;

	modport opsel (input is_cmps_first, is_cmps_second, repne_steady);
	modport fu (input aluk, size);
	modport rs (
		input is_alu32, is_cmps_first, is_cmps_second, is_xchg, pass_a,
		input is_cmpxchg, mux_sp_pop, flags_from_alu, alu_to_b
	);
	modport wb (input is_cmpxchg, ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, dcache_write, repne);

endinterface

`default_nettype wire

/* hw/ex_alu32.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_alu32 (
	input  logic [ex_pkg::DATA_W-1:0] a,
	input  logic [ex_pkg::DATA_W-1:0] b,
	input  ex_pkg::alu_op_e           op,
	input  ex_pkg::data_size_e        size,
	input  logic                      cf_in,
	input  logic                      af_in,
	output logic [ex_pkg::DATA_W-1:0] result,
	output logic [ex_pkg::DATA_W-1:0] flags
);
	import ex_pkg::*;

	logic [DATA_W-1:0] mask;
	logic [DATA_W-1:0] a_m;
	logic [DATA_W-1:0] b_m;
	// one spare bit above the word for carry and borrow
	logic [DATA_W:0]   raw;
	logic              carry;
	logic              a_sign;
	logic              b_sign;
	logic              r_sign;

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	always_comb begin
		mask = size_mask(size);
		a_m  = a & mask;
		b_m  = b & mask;
		case (op)
			ALU_ADD: raw = {1'b0, a_m} + {1'b0, b_m};
			ALU_ADC: raw = {1'b0, a_m} + {1'b0, b_m} + (DATA_W+1)'(cf_in);
			ALU_SUB: raw = {1'b0, a_m} - {1'b0, b_m};
			ALU_OR:  raw = {1'b0, a_m | b_m};
			ALU_AND: raw = {1'b0, a_m & b_m};
			ALU_XOR: raw = {1'b0, a_m ^ b_m};
			ALU_NOT: raw = {1'b0, ~a_m};
			default: raw = {1'b0, b_m};
		endcase
		// upper bits zero for byte and word
		result = raw[DATA_W-1:0] & mask;
	end

	// carry out of the top bit at the operand size, borrow for sub
	always_comb begin
		case (size)
			SIZE_BYTE: carry = raw[8];
			SIZE_WORD: carry = raw[16];
			default:   carry = raw[DATA_W];
		endcase
	end

	assign a_sign = sign_bit(a_m, size);
	assign b_sign = sign_bit(b_m, size);
	assign r_sign = sign_bit(result, size);

	// --------------------------------------------------
	// flags
	// --------------------------------------------------
	always_comb begin
		flags          = '0;
		flags[FLAG_PF] = ~^result[7:0];
		flags[FLAG_ZF] = (result == '0);
		flags[FLAG_SF] = r_sign;
		case (op)
			ALU_ADD, ALU_ADC: begin
				flags[FLAG_CF] = carry;
				flags[FLAG_AF] = a_m[4] ^ b_m[4] ^ result[4];
				flags[FLAG_OF] = (a_sign == b_sign) && (r_sign != a_sign);
			end
			ALU_SUB: begin
				flags[FLAG_CF] = carry;
				flags[FLAG_AF] = a_m[4] ^ b_m[4] ^ result[4];
				flags[FLAG_OF] = (a_sign != b_sign) && (r_sign != a_sign);
			end
			ALU_OR, ALU_AND, ALU_XOR: begin
				flags[FLAG_CF] = 1'b0;
				flags[FLAG_AF] = af_in;
				flags[FLAG_OF] = 1'b0;
			end
			default: begin
				// not and pass keep the incoming carry and aux carry
				flags[FLAG_CF] = cf_in;
				flags[FLAG_AF] = af_in;
				flags[FLAG_OF] = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/ex_operand_select.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_operand_select (
	input  logic                      CLK,
	input  logic                      rst_n,
	ex_ctrl_if.opsel                  ctrl,
	input  logic [ex_pkg::DATA_W-1:0] ex_a,
	input  logic [ex_pkg::DATA_W-1:0] ex_b,
	input  logic [ex_pkg::DATA_W-1:0] ex_c,
	input  logic [ex_pkg::DATA_W-1:0] count_fwd,
	output logic [ex_pkg::DATA_W-1:0] b,
	output logic [ex_pkg::DATA_W-1:0] count
);
	import ex_pkg::*;

	logic [DATA_W-1:0] cmps_first_q;

	// first string operand, held until the second micro-op
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			cmps_first_q <= '0;
		end else if (ctrl.is_cmps_first) begin
			cmps_first_q <= ex_a;
		end
	end

	assign b     = ctrl.is_cmps_second ? cmps_first_q : ex_b;
	// loop count comes forwarded once repne is running
	assign count = ctrl.repne_steady ? count_fwd : ex_c;

	// decode never issues both halves of cmps in one cycle
	a_cmps_halves_exclusive: assert property (
		@(posedge CLK) disable iff (!rst_n)
		!(ctrl.is_cmps_first && ctrl.is_cmps_second)
	);

endmodule

`default_nettype wire

/* hw/ex_functional_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_functional_unit (
	ex_ctrl_if.fu                     ctrl,
	input  logic [ex_pkg::DATA_W-1:0] ex_a,
	input  logic [ex_pkg::DATA_W-1:0] ex_c,
	input  logic [ex_pkg::DATA_W-1:0] b,
	input  logic [ex_pkg::DATA_W-1:0] count,
	input  logic [ex_pkg::DATA_W-1:0] flags_fwd,
	output logic [ex_pkg::DATA_W-1:0] alu_result,
	output logic [ex_pkg::DATA_W-1:0] alu_flags,
	output logic [ex_pkg::DATA_W-1:0] shift_result,
	output logic [ex_pkg::DATA_W-1:0] shift_flags,
	output logic [ex_pkg::DATA_W-1:0] count_minus_one,
	output logic [ex_pkg::DATA_W-1:0] sp_pop
);
	import ex_pkg::*;

	logic [DATA_W-1:0] shift_mask;
	logic [DATA_W-1:0] shift_in;
	logic              shift_out;

	ex_alu32 u_alu32 (
		.a      (ex_a),
		.b      (b),
		.op     (ctrl.aluk),
		.size   (ctrl.size),
		.cf_in  (flags_fwd[FLAG_CF]),
		.af_in  (flags_fwd[FLAG_AF]),
		.result (alu_result),
		.flags  (alu_flags)
	);

	// --------------------------------------------------
	// one-bit shifter, aluk[0] picks right
	// --------------------------------------------------
	always_comb begin
		shift_mask = size_mask(ctrl.size);
		shift_in   = ex_a & shift_mask;
		if (ctrl.aluk[0]) begin
			shift_result = shift_in >> 1;
			shift_out    = shift_in[0];
		end else begin
			shift_result = (shift_in << 1) & shift_mask;
			shift_out    = sign_bit(shift_in, ctrl.size);
		end
		// af and of pass through untouched
		shift_flags          = flags_fwd;
		shift_flags[FLAG_CF] = shift_out;
		shift_flags[FLAG_PF] = ~^shift_result[7:0];
		shift_flags[FLAG_ZF] = (shift_result == '0);
		shift_flags[FLAG_SF] = sign_bit(shift_result, ctrl.size);
	end

	assign count_minus_one = count - DATA_W'(1);
	assign sp_pop          = ex_c + size_bytes(ctrl.size);

endmodule

`default_nettype wire

/* hw/ex_result_select.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_result_select (
	ex_ctrl_if.rs                     ctrl,
	input  logic [ex_pkg::DATA_W-1:0] ex_a,
	input  logic [ex_pkg::DATA_W-1:0] ex_b,
	input  logic [ex_pkg::DATA_W-1:0] ex_c,
	input  logic [ex_pkg::DATA_W-1:0] alu_result,
	input  logic [ex_pkg::DATA_W-1:0] alu_flags,
	input  logic [ex_pkg::DATA_W-1:0] shift_result,
	input  logic [ex_pkg::DATA_W-1:0] shift_flags,
	input  logic [ex_pkg::DATA_W-1:0] sp_pop,
	input  logic [ex_pkg::DATA_W-1:0] count_minus_one,
	output logic [ex_pkg::DATA_W-1:0] result_a,
	output logic [ex_pkg::DATA_W-1:0] result_b,
	output logic [ex_pkg::DATA_W-1:0] result_c,
	output logic [ex_pkg::DATA_W-1:0] flags
);
	import ex_pkg::*;

	logic b_into_a;
	logic a_into_b;

	assign b_into_a = ctrl.is_cmps_first | ctrl.is_xchg;
	assign a_into_b = ctrl.is_xchg | ctrl.is_cmpxchg;

	// --------------------------------------------------
	// result a, alu wins over everything
	// --------------------------------------------------
	always_comb begin
		if (ctrl.is_alu32) begin
			result_a = alu_result;
		end else if (b_into_a) begin
			result_a = ex_b;
		end else if (ctrl.pass_a) begin
			result_a = ex_a;
		end else if (ctrl.is_cmpxchg) begin
			result_a = ex_c;
		end else begin
			result_a = shift_result;
		end
	end

	always_comb begin
		if (ctrl.alu_to_b) begin
			result_b = alu_result;
		end else if (a_into_b) begin
			result_b = ex_a;
		end else begin
			result_b = ex_b;
		end
	end

	// count on cmps, stack pointer on pop, else untouched
	always_comb begin
		if (ctrl.is_cmps_second) begin
			result_c = count_minus_one;
		end else if (ctrl.mux_sp_pop) begin
			result_c = sp_pop;
		end else begin
			result_c = ex_c;
		end
	end

	assign flags = ctrl.flags_from_alu ? alu_flags : shift_flags;

endmodule

`default_nettype wire

/* hw/ex_wb_latch.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_wb_latch (
	input  logic                      CLK,
	input  logic                      rst_n,
	ex_ctrl_if.wb                     ctrl,
	input  logic                      ex_v,
	input  logic                      wb_stall,
	input  logic                      repne_terminate,
	input  logic [ex_pkg::DATA_W-1:0] alu_flags,
	input  logic [ex_pkg::DATA_W-1:0] result_a,
	input  logic [ex_pkg::DATA_W-1:0] result_b,
	input  logic [ex_pkg::DATA_W-1:0] result_c,
	input  logic [ex_pkg::DATA_W-1:0] flags,
	output logic [ex_pkg::DATA_W-1:0] wb_result_a,
	output logic [ex_pkg::DATA_W-1:0] wb_result_b,
	output logic [ex_pkg::DATA_W-1:0] wb_result_c,
	output logic [ex_pkg::DATA_W-1:0] wb_flags,
	output logic                      wb_v,
	output logic                      wb_ld_gpr1,
	output logic                      wb_ld_gpr2,
	output logic                      wb_ld_gpr3,
	output logic                      wb_ld_seg,
	output logic                      wb_dcache_write
);
	import ex_pkg::*;

	logic zf;
	logic ld_gpr1_x;
	logic ld_gpr2_x;
	logic dcache_write_x;
	logic v_next;

	// --------------------------------------------------
	// cmpxchg writes dest only on match and loads the accumulator otherwise
	// --------------------------------------------------
	assign zf             = alu_flags[FLAG_ZF];
	assign ld_gpr1_x      = ctrl.is_cmpxchg ? (ctrl.ld_gpr1 & zf) : ctrl.ld_gpr1;
	assign ld_gpr2_x      = ctrl.is_cmpxchg ? ~zf : ctrl.ld_gpr2;
	assign dcache_write_x = ctrl.is_cmpxchg ? (ctrl.dcache_write & zf) : ctrl.dcache_write;

	// repne iteration becomes a bubble until it terminates
	assign v_next = ctrl.repne ? (ex_v & repne_terminate) : ex_v;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_result_a     <= '0;
			wb_result_b     <= '0;
			wb_result_c     <= '0;
			wb_flags        <= '0;
			wb_v            <= 1'b0;
			wb_ld_gpr1      <= 1'b0;
			wb_ld_gpr2      <= 1'b0;
			wb_ld_gpr3      <= 1'b0;
			wb_ld_seg       <= 1'b0;
			wb_dcache_write <= 1'b0;
		end else if (!wb_stall) begin
			wb_result_a     <= result_a;
			wb_result_b     <= result_b;
			wb_result_c     <= result_c;
			wb_flags        <= flags;
			wb_v            <= v_next;
			wb_ld_gpr1      <= ex_v & ld_gpr1_x;
			wb_ld_gpr2      <= ex_v & ld_gpr2_x;
			wb_ld_gpr3      <= ex_v & ctrl.ld_gpr3;
			wb_ld_seg       <= ex_v & ctrl.ld_seg;
			wb_dcache_write <= ex_v & dcache_write_x;
		end
	end

	// no write enable reaches wb without a valid op
	a_enables_need_valid: assert property (
		@(posedge CLK) disable iff (!rst_n)
		!wb_v |-> !(wb_ld_gpr1 | wb_ld_gpr2 | wb_ld_gpr3 | wb_ld_seg | wb_dcache_write)
	);

endmodule

`default_nettype wire

/* hw/ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
	input  logic                      CLK,
	input  logic                      rst_n,
	// decoded control
	input  logic                      is_cmps_first,
	input  logic                      is_cmps_second,
	input  logic                      repne_steady,
	input  logic                      is_cmpxchg,
	input  logic                      is_xchg,
	input  logic                      pass_a,
	input  logic                      mux_sp_pop,
	input  logic                      flags_from_alu,
	input  logic                      alu_to_b,
	input  logic                      is_alu32,
	input  ex_pkg::alu_op_e           aluk,
	input  ex_pkg::data_size_e        size,
	input  logic                      ld_gpr1,
	input  logic                      ld_gpr2,
	input  logic                      ld_gpr3,
	input  logic                      ld_seg,
	input  logic                      dcache_write,
	input  logic                      repne,
	// operands and forwarded state
	input  logic [ex_pkg::DATA_W-1:0] ex_a,
	input  logic [ex_pkg::DATA_W-1:0] ex_b,
	input  logic [ex_pkg::DATA_W-1:0] ex_c,
	input  logic                      ex_v,
	input  logic [ex_pkg::DATA_W-1:0] count_fwd,
	input  logic [ex_pkg::DATA_W-1:0] flags_fwd,
	input  logic                      wb_stall,
	input  logic                      repne_terminate,
	// ex/wb latch
	output logic [ex_pkg::DATA_W-1:0] wb_result_a,
	output logic [ex_pkg::DATA_W-1:0] wb_result_b,
	output logic [ex_pkg::DATA_W-1:0] wb_result_c,
	output logic [ex_pkg::DATA_W-1:0] wb_flags,
	output logic                      wb_v,
	output logic                      wb_ld_gpr1,
	output logic                      wb_ld_gpr2,
	output logic                      wb_ld_gpr3,
	output logic                      wb_ld_seg,
	output logic                      wb_dcache_write
);
	import ex_pkg::*;

	logic [DATA_W-1:0] b_op;
	logic [DATA_W-1:0] count_op;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] alu_flags;
	logic [DATA_W-1:0] shift_result;
	logic [DATA_W-1:0] shift_flags;
	logic [DATA_W-1:0] count_minus_one;
	logic [DATA_W-1:0] sp_pop;
	logic [DATA_W-1:0] result_a;
	logic [DATA_W-1:0] result_b;
	logic [DATA_W-1:0] result_c;
	logic [DATA_W-1:0] flags_sel;

	ex_ctrl_if ctrl ();

	assign ctrl.is_cmps_first  = is_cmps_first;
	assign ctrl.is_cmps_second = is_cmps_second;
	assign ctrl.repne_steady   = repne_steady;
	assign ctrl.repne          = repne;
	assign ctrl.is_cmpxchg     = is_cmpxchg;
	assign ctrl.is_xchg        = is_xchg;
	assign ctrl.pass_a         = pass_a;
	assign ctrl.mux_sp_pop     = mux_sp_pop;
	assign ctrl.flags_from_alu = flags_from_alu;
	assign ctrl.alu_to_b       = alu_to_b;
	assign ctrl.is_alu32       = is_alu32;
	assign ctrl.aluk           = aluk;
	assign ctrl.size           = size;
	assign ctrl.ld_gpr1        = ld_gpr1;
	assign ctrl.ld_gpr2        = ld_gpr2;
	assign ctrl.ld_gpr3        = ld_gpr3;
	assign ctrl.ld_seg         = ld_seg;
	assign ctrl.dcache_write   = dcache_write;

	// --------------------------------------------------
	// stage datapath
	// --------------------------------------------------
	ex_operand_select u_operand_select (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.ctrl      (ctrl.opsel),
		.ex_a      (ex_a),
		.ex_b      (ex_b),
		.ex_c      (ex_c),
		.count_fwd (count_fwd),
		.b         (b_op),
		.count     (count_op)
	);

	ex_functional_unit u_functional_unit (
		.ctrl            (ctrl.fu),
		.ex_a            (ex_a),
		.ex_c            (ex_c),
		.b               (b_op),
		.count           (count_op),
		.flags_fwd       (flags_fwd),
		.alu_result      (alu_result),
		.alu_flags       (alu_flags),
		.shift_result    (shift_result),
		.shift_flags     (shift_flags),
		.count_minus_one (count_minus_one),
		.sp_pop          (sp_pop)
	);

	ex_result_select u_result_select (
		.ctrl            (ctrl.rs),
		.ex_a            (ex_a),
		.ex_b            (ex_b),
		.ex_c            (ex_c),
		.alu_result      (alu_result),
		.alu_flags       (alu_flags),
		.shift_result    (shift_result),
		.shift_flags     (shift_flags),
		.sp_pop          (sp_pop),
		.count_minus_one (count_minus_one),
		.result_a        (result_a),
		.result_b        (result_b),
		.result_c        (result_c),
		.flags           (flags_sel)
	);

	ex_wb_latch u_wb_latch (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.ctrl            (ctrl.wb),
		.ex_v            (ex_v),
		.wb_stall        (wb_stall),
		.repne_terminate (repne_terminate),
		.alu_flags       (alu_flags),
		.result_a        (result_a),
		.result_b        (result_b),
		.result_c        (result_c),
		.flags           (flags_sel),
		.wb_result_a     (wb_result_a),
		.wb_result_b     (wb_result_b),
		.wb_result_c     (wb_result_c),
		.wb_flags        (wb_flags),
		.wb_v            (wb_v),
		.wb_ld_gpr1      (wb_ld_gpr1),
		.wb_ld_gpr2      (wb_ld_gpr2),
		.wb_ld_gpr3      (wb_ld_gpr3),
		.wb_ld_seg       (wb_ld_seg),
		.wb_dcache_write (wb_dcache_write)
	);

endmodule

`default_nettype wire

/* verif/tb_ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;
	import ex_pkg::*;

	localparam int ALU_REPS       = 4;
	localparam int SHIFT_REPS     = 4;
	localparam int RESET_CYCLES   = 16;
	// reset plus the alu and shifter sweeps and the short directed tests
	localparam int TEST_CYCLES    = RESET_CYCLES + ALU_REPS * 8 * 3 + SHIFT_REPS * 2 * 3 + 20;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	localparam logic [DATA_W-1:0] FLAG_MASK = (DATA_W'(1) << FLAG_CF) | (DATA_W'(1) << FLAG_PF) |
		(DATA_W'(1) << FLAG_AF) | (DATA_W'(1) << FLAG_ZF) | (DATA_W'(1) << FLAG_SF) |
		(DATA_W'(1) << FLAG_OF);

	logic              clk;
	logic              rst_n;
	logic              is_cmps_first;
	logic              is_cmps_second;
	logic              repne_steady;
	logic              is_cmpxchg;
	logic              is_xchg;
	logic              pass_a;
	logic              mux_sp_pop;
	logic              flags_from_alu;
	logic              alu_to_b;
	logic              is_alu32;
	alu_op_e           aluk;
	data_size_e        size;
	logic              ld_gpr1;
	logic              ld_gpr2;
	logic              ld_gpr3;
	logic              ld_seg;
	logic              dcache_write;
	logic              repne;
	logic [DATA_W-1:0] ex_a;
	logic [DATA_W-1:0] ex_b;
	logic [DATA_W-1:0] ex_c;
	logic              ex_v;
	logic [DATA_W-1:0] count_fwd;
	logic [DATA_W-1:0] flags_fwd;
	logic              wb_stall;
	logic              repne_terminate;
	logic [DATA_W-1:0] wb_result_a;
	logic [DATA_W-1:0] wb_result_b;
	logic [DATA_W-1:0] wb_result_c;
	logic [DATA_W-1:0] wb_flags;
	logic              wb_v;
	logic              wb_ld_gpr1;
	logic              wb_ld_gpr2;
	logic              wb_ld_gpr3;
	logic              wb_ld_seg;
	logic              wb_dcache_write;
	logic [5:0]        wb_enables;

	int    cycle_count;
	int    checks;
	int    errors;
	int    tests_run;
	int    tests_failed;
	int    errors_at_start;
	string test_name;

	ex_stage u_ex_stage (
		.CLK (clk), .rst_n (rst_n),
		.is_cmps_first (is_cmps_first), .is_cmps_second (is_cmps_second),
		.repne_steady (repne_steady), .is_cmpxchg (is_cmpxchg), .is_xchg (is_xchg),
		.pass_a (pass_a), .mux_sp_pop (mux_sp_pop), .flags_from_alu (flags_from_alu),
		.alu_to_b (alu_to_b), .is_alu32 (is_alu32), .aluk (aluk), .size (size),
		.ld_gpr1 (ld_gpr1), .ld_gpr2 (ld_gpr2), .ld_gpr3 (ld_gpr3), .ld_seg (ld_seg),
		.dcache_write (dcache_write), .repne (repne),
		.ex_a (ex_a), .ex_b (ex_b), .ex_c (ex_c), .ex_v (ex_v),
		.count_fwd (count_fwd), .flags_fwd (flags_fwd),
		.wb_stall (wb_stall), .repne_terminate (repne_terminate),
		.wb_result_a (wb_result_a), .wb_result_b (wb_result_b), .wb_result_c (wb_result_c),
		.wb_flags (wb_flags), .wb_v (wb_v),
		.wb_ld_gpr1 (wb_ld_gpr1), .wb_ld_gpr2 (wb_ld_gpr2), .wb_ld_gpr3 (wb_ld_gpr3),
		.wb_ld_seg (wb_ld_seg), .wb_dcache_write (wb_dcache_write)
	);

	// valid followed by the enables in port order
	assign wb_enables = {wb_v, wb_ld_gpr1, wb_ld_gpr2, wb_ld_gpr3, wb_ld_seg, wb_dcache_write};

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count > TIMEOUT_CYCLES) begin
				$display("run stopped after %0d cycles without finishing the tests", cycle_count);
				$display("TEST FAIL");
				$finish;
			end
		end
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic int width_bits(input data_size_e sz);
		case (sz)
			SIZE_BYTE: return 8;
			SIZE_WORD: return 16;
			default:   return 32;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] live_mask(input int w);
		if (w >= 32)
			return 32'hffff_ffff;
		return (32'h1 << w) - 32'h1;
	endfunction

	function automatic logic [DATA_W-1:0] pop_increment(input data_size_e sz);
		return DATA_W'(width_bits(sz) / 8);
	endfunction

	function automatic void expected_alu(input alu_op_e op, input data_size_e sz,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			input logic cf, input logic af,
			output logic [DATA_W-1:0] res, output logic [DATA_W-1:0] fl);
		int              w;
		logic [DATA_W-1:0] m;
		logic [DATA_W-1:0] am;
		logic [DATA_W-1:0] bm;
		logic [DATA_W:0]   sum;
		logic            sa;
		logic            sb;
		logic            sr;
		w   = width_bits(sz);
		m   = live_mask(w);
		am  = a & m;
		bm  = b & m;
		fl  = '0;
		case (op)
			ALU_ADD: sum = {1'b0, am} + {1'b0, bm};
			ALU_ADC: sum = {1'b0, am} + {1'b0, bm} + 33'(cf);
			ALU_SUB: sum = {1'b0, am - bm};
			ALU_OR:  sum = {1'b0, am | bm};
			ALU_AND: sum = {1'b0, am & bm};
			ALU_XOR: sum = {1'b0, am ^ bm};
			ALU_NOT: sum = {1'b0, ~am};
			default: sum = {1'b0, bm};
		endcase
		res = sum[DATA_W-1:0] & m;
		sa  = am[w-1];
		sb  = bm[w-1];
		sr  = res[w-1];
		fl[FLAG_PF] = ~^res[7:0];
		fl[FLAG_ZF] = (res == '0);
		fl[FLAG_SF] = sr;
		case (op)
			ALU_ADD, ALU_ADC: begin
				fl[FLAG_CF] = sum[w];
				fl[FLAG_AF] = am[4] ^ bm[4] ^ res[4];
				fl[FLAG_OF] = (sa == sb) && (sr != sa);
			end
			ALU_SUB: begin
				// borrow out of the top bit
				fl[FLAG_CF] = (am < bm);
				fl[FLAG_AF] = am[4] ^ bm[4] ^ res[4];
				fl[FLAG_OF] = (sa != sb) && (sr != sa);
			end
			ALU_OR, ALU_AND, ALU_XOR: begin
				fl[FLAG_AF] = af;
			end
			default: begin
				fl[FLAG_CF] = cf;
				fl[FLAG_AF] = af;
			end
		endcase
	endfunction

	function automatic void expected_shift(input logic right, input data_size_e sz,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] fwd,
			output logic [DATA_W-1:0] res, output logic [DATA_W-1:0] fl);
		int              w;
		logic [DATA_W-1:0] m;
		logic [DATA_W-1:0] am;
		w  = width_bits(sz);
		m  = live_mask(w);
		am = a & m;
		fl = fwd;
		if (right) begin
			res         = am >> 1;
			fl[FLAG_CF] = am[0];
		end else begin
			res         = (am << 1) & m;
			fl[FLAG_CF] = am[w-1];
		end
		fl[FLAG_PF] = ~^res[7:0];
		fl[FLAG_ZF] = (res == '0);
		fl[FLAG_SF] = res[w-1];
	endfunction

	// --------------------------------------------------
	// compare tasks and bookkeeping
	// --------------------------------------------------
	task automatic check_word(input string what, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_flags(input string what, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		checks++;
		if ((act & FLAG_MASK) !== (exp & FLAG_MASK)) begin
			errors++;
			$display("Error %s %s: expected %h actual %h (mask %h)", test_name, what,
				exp & FLAG_MASK, act & FLAG_MASK, FLAG_MASK);
		end
	endtask

	task automatic check_enables(input string what, input logic [5:0] exp, input logic [5:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s %s: expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic clear_controls();
		is_cmps_first   = 1'b0;
		is_cmps_second  = 1'b0;
		repne_steady    = 1'b0;
		is_cmpxchg      = 1'b0;
		is_xchg         = 1'b0;
		pass_a          = 1'b0;
		mux_sp_pop      = 1'b0;
		flags_from_alu  = 1'b0;
		alu_to_b        = 1'b0;
		is_alu32        = 1'b0;
		aluk            = ALU_ADD;
		size            = SIZE_DWORD;
		ld_gpr1         = 1'b0;
		ld_gpr2         = 1'b0;
		ld_gpr3         = 1'b0;
		ld_seg          = 1'b0;
		dcache_write    = 1'b0;
		repne           = 1'b0;
		ex_v            = 1'b0;
		wb_stall        = 1'b0;
		repne_terminate = 1'b0;
		flags_fwd       = '0;
	endtask

	// inputs change on the falling edge and the latch is read one falling edge later
	task automatic next_cycle();
		@(negedge clk);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic test_reset_state();
		start_test("reset_state");
		check_word("wb_result_a", '0, wb_result_a);
		check_word("wb_result_b", '0, wb_result_b);
		check_word("wb_result_c", '0, wb_result_c);
		check_word("wb_flags", '0, wb_flags);
		check_enables("enables", 6'b000000, wb_enables);
		end_test();
	endtask

	task automatic test_alu_ops();
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] fl;
		start_test("alu_ops");
		for (int op = 0; op < 8; op++) begin
			for (int sz = 0; sz < 3; sz++) begin
				for (int rep = 0; rep < ALU_REPS; rep++) begin
					clear_controls();
					is_alu32       = 1'b1;
					flags_from_alu = 1'b1;
					ex_v           = 1'b1;
					aluk           = alu_op_e'(op);
					size           = data_size_e'(sz);
					ex_a           = $urandom;
					// first pass of each combination compares equal values
					ex_b           = (rep == 0) ? ex_a : $urandom;
					flags_fwd      = $urandom;
					expected_alu(aluk, size, ex_a, ex_b, flags_fwd[FLAG_CF],
						flags_fwd[FLAG_AF], res, fl);
					next_cycle();
					check_word("wb_result_a", res, wb_result_a);
					check_flags("wb_flags", fl, wb_flags);
				end
			end
		end
		end_test();
	endtask

	task automatic test_shifter();
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] fl;
		start_test("shifter");
		for (int dir = 0; dir < 2; dir++) begin
			for (int sz = 0; sz < 3; sz++) begin
				for (int rep = 0; rep < SHIFT_REPS; rep++) begin
					clear_controls();
					ex_v      = 1'b1;
					aluk      = (dir == 1) ? ALU_OR : ALU_ADD;
					size      = data_size_e'(sz);
					ex_a      = $urandom;
					flags_fwd = $urandom;
					expected_shift(dir == 1, size, ex_a, flags_fwd, res, fl);
					next_cycle();
					check_word("wb_result_a", res, wb_result_a);
					check_flags("wb_flags", fl, wb_flags);
				end
			end
		end
		end_test();
	endtask

	task automatic test_cmps_pair();
		logic [DATA_W-1:0] first_op;
		logic [DATA_W-1:0] cnt;
		logic [DATA_W-1:0] res;
		logic [DATA_W-1:0] fl;
		start_test("cmps_pair");
		first_op = $urandom;
		clear_controls();
		is_cmps_first = 1'b1;
		ex_v          = 1'b1;
		ex_a          = first_op;
		ex_b          = $urandom;
		next_cycle();
		check_word("wb_result_a", ex_b, wb_result_a);
		// second half compares against the stored first operand
		clear_controls();
		is_cmps_second = 1'b1;
		flags_from_alu = 1'b1;
		aluk           = ALU_SUB;
		ex_v           = 1'b1;
		ex_a           = $urandom;
		ex_b           = $urandom;
		cnt            = $urandom;
		ex_c           = cnt;
		expected_alu(ALU_SUB, SIZE_DWORD, ex_a, first_op, 1'b0, 1'b0, res, fl);
		next_cycle();
		check_word("wb_result_c", cnt - 32'd1, wb_result_c);
		check_flags("wb_flags", fl, wb_flags);
		// steady repne takes the forwarded count
		repne_steady = 1'b1;
		ex_a         = first_op;
		ex_c         = $urandom;
		cnt          = $urandom;
		count_fwd    = cnt;
		expected_alu(ALU_SUB, SIZE_DWORD, ex_a, first_op, 1'b0, 1'b0, res, fl);
		next_cycle();
		check_word("wb_result_c", cnt - 32'd1, wb_result_c);
		check_flags("wb_flags", fl, wb_flags);
		end_test();
	endtask

	task automatic test_cmpxchg();
		start_test("cmpxchg");
		for (int equal = 1; equal >= 0; equal--) begin
			clear_controls();
			is_cmpxchg     = 1'b1;
			flags_from_alu = 1'b1;
			aluk           = ALU_SUB;
			ex_v           = 1'b1;
			ld_gpr1        = 1'b1;
			dcache_write   = 1'b1;
			ex_a           = $urandom;
			ex_b           = (equal == 1) ? ex_a : ex_a ^ 32'h0000_0100;
			ex_c           = $urandom;
			next_cycle();
			check_word("wb_result_b", ex_a, wb_result_b);
			if (equal == 1)
				check_enables("enables", 6'b110001, wb_enables);
			else
				check_enables("enables", 6'b101000, wb_enables);
		end
		end_test();
	endtask

	task automatic test_xchg_pop();
		start_test("xchg_pop");
		clear_controls();
		is_xchg = 1'b1;
		ex_v    = 1'b1;
		ex_a    = $urandom;
		ex_b    = $urandom;
		next_cycle();
		check_word("wb_result_a", ex_b, wb_result_a);
		check_word("wb_result_b", ex_a, wb_result_b);
		for (int sz = 0; sz < 3; sz++) begin
			clear_controls();
			mux_sp_pop = 1'b1;
			ex_v       = 1'b1;
			size       = data_size_e'(sz);
			ex_c       = $urandom;
			next_cycle();
			check_word("wb_result_c", ex_c + pop_increment(size), wb_result_c);
		end
		end_test();
	endtask

	task automatic test_valid_stall();
		logic [DATA_W-1:0] held_a;
		logic [DATA_W-1:0] held_b;
		logic [DATA_W-1:0] held_c;
		logic [DATA_W-1:0] shift_res;
		logic [DATA_W-1:0] held_fl;
		start_test("valid_stall");
		// bubble drops every enable
		clear_controls();
		{ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, dcache_write} = 5'b11111;
		next_cycle();
		check_enables("bubble enables", 6'b000000, wb_enables);
		clear_controls();
		is_xchg = 1'b1;
		ex_v    = 1'b1;
		{ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, dcache_write} = 5'b10110;
		held_a  = $urandom;
		held_b  = $urandom;
		held_c  = $urandom;
		ex_a    = held_a;
		ex_b    = held_b;
		ex_c    = held_c;
		// xchg leaves the left-shift flags on the flags path
		expected_shift(1'b0, SIZE_DWORD, held_a, '0, shift_res, held_fl);
		next_cycle();
		check_enables("valid enables", 6'b110110, wb_enables);
		// new inputs must not reach the latch while stalled
		wb_stall = 1'b1;
		ex_v     = 1'b0;
		ex_a     = ~held_a;
		ex_b     = ~held_b;
		ex_c     = ~held_c;
		next_cycle();
		check_word("held wb_result_a", held_b, wb_result_a);
		check_word("held wb_result_b", held_a, wb_result_b);
		check_word("held wb_result_c", held_c, wb_result_c);
		check_flags("held wb_flags", held_fl, wb_flags);
		check_enables("held enables", 6'b110110, wb_enables);
		wb_stall = 1'b0;
		next_cycle();
		check_word("released wb_result_a", ~held_b, wb_result_a);
		check_enables("released enables", 6'b000000, wb_enables);
		// repne iterations stay bubbles until terminate
		clear_controls();
		repne = 1'b1;
		ex_v  = 1'b1;
		next_cycle();
		check_enables("repne running", 6'b000000, wb_enables);
		repne_terminate = 1'b1;
		next_cycle();
		check_enables("repne done", 6'b100000, wb_enables);
		end_test();
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(26));
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n        = 1'b0;
		ex_a         = '0;
		ex_b         = '0;
		ex_c         = '0;
		count_fwd    = '0;
		clear_controls();
		repeat (RESET_CYCLES) @(negedge clk);
		test_reset_state();
		rst_n = 1'b1;
		test_alu_ops();
		test_shifter();
		test_cmps_pair();
		test_cmpxchg();
		test_xchg_pop();
		test_valid_stall();
		$display("tests %0d, failing %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* ex_stage.f */
hw/ex_pkg.sv
hw/ex_ctrl_if.sv
hw/ex_alu32.sv
hw/ex_operand_select.sv
hw/ex_functional_unit.sv
hw/ex_result_select.sv
hw/ex_wb_latch.sv
hw/ex_stage.sv
verif/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - hw/ex_pkg.sv
  - hw/ex_ctrl_if.sv
  - hw/ex_alu32.sv
  - hw/ex_operand_select.sv
  - hw/ex_functional_unit.sv
  - hw/ex_result_select.sv
  - hw/ex_wb_latch.sv
  - hw/ex_stage.sv
  - target: test
    files:
      - verif/tb_ex_stage.sv
